// ==== rtl/hwl_pkg.sv ====
package hwl_pkg;

  // --------------------------------------------------
  // sizes and fixed addresses
  // --------------------------------------------------

  // entries in the loop register file
  localparam int HWL_DEPTH = 8;

  // word index zero maps here
  localparam logic [31:0] HWL_BASE_PC = 32'h1000_0000;

  // custom opcodes seen in inst[6:0]
  localparam logic [6:0] HWL_OPC_CFG = 7'h3C;
  localparam logic [6:0] HWL_OPC_MERGE = 7'h14;

  // merge also needs this funct3 in inst[14:12]
  localparam logic [2:0] HWL_F3_MERGE = 3'h2;

  // fetch select codes toward next pc mux
  localparam logic [1:0] HWL_PCSEL_SEQ = 2'd0;
  localparam logic [1:0] HWL_PCSEL_LOOP = 2'd2;

  // --------------------------------------------------
  // types
  // --------------------------------------------------

  // nesting level, 0 means no active loop
  typedef logic [2:0] hwl_level_t;

  // one loop register entry
  // start in 31:23, len in 22:17, tag in 16:12, count in 11:0
  typedef struct packed {
    // first word of the loop body
    logic [8:0] start;
    // body length in words
    logic [5:0] len;
    // reserved
    logic [4:0] tag;
    // iterations still to go
    logic [11:0] count;
  } hwl_entry_t;

  // decoded instruction kind
  typedef enum logic [1:0] {
    op_none = 2'd0,
    op_cfg = 2'd1,
    op_merge = 2'd2
  } hwl_op_e;

  // command into the register file
  typedef struct packed {
    hwl_op_e op;
    // target entry
    logic [2:0] addr;
    // write data on cfg, immediate on merge
    logic [31:0] data;
  } hwl_cmd_t;

endpackage

// ==== rtl/hwl_loop_regfile.sv ====
`timescale 1ns/1ps

module hwl_loop_regfile (
  input  logic                             clk,
  input  logic                             rst,
  input  hwl_pkg::hwl_cmd_t                cmd,
  input  hwl_pkg::hwl_level_t              level,
  input  logic                             dec,
  output hwl_pkg::hwl_entry_t              cur,
  output logic [hwl_pkg::HWL_DEPTH-1:0]    zero_vec
);

  // --------------------------------------------------
  // storage
  // --------------------------------------------------

  // entry 0 is never active, level 0 means idle
  hwl_pkg::hwl_entry_t ent [hwl_pkg::HWL_DEPTH];

  // merged value for the addressed entry
  logic [31:0] merged;

  assign merged = ent[cmd.addr] | cmd.data;

  // write side
  // cfg and merge take priority over the decrement
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < hwl_pkg::HWL_DEPTH; i++) begin
        ent[i] <= '0;
      end
    end else begin
      case (cmd.op)
        hwl_pkg::op_cfg: begin
          // full overwrite
          ent[cmd.addr] <= hwl_pkg::hwl_entry_t'(cmd.data);
        end
        hwl_pkg::op_merge: begin
          // or in the immediate
          ent[cmd.addr] <= hwl_pkg::hwl_entry_t'(merged);
        end
        default: begin
          // one more trip through the active body
          if (dec) begin
            ent[level].count <= ent[level].count - 12'd1;
          end
        end
      endcase
    end
  end

  // --------------------------------------------------
  // read side
  // --------------------------------------------------

  // active entry picked by level
  assign cur = ent[level];

  // per entry count-is-zero flags
  // used by the exit counter to pop nested levels together
  always_comb begin
    for (int i = 0; i < hwl_pkg::HWL_DEPTH; i++) begin
      zero_vec[i] = (ent[i].count == 12'd0);
    end
  end

endmodule

// ==== rtl/hwl_level_tracker.sv ====
`timescale 1ns/1ps

module hwl_level_tracker (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [31:0]           inst,
  input  logic                  ena_inst,
  input  logic [2:0]            wa,
  input  logic [31:0]           wd,
  input  logic [31:0]           imm,
  input  logic                  fall_thru,
  input  hwl_pkg::hwl_level_t   pop,
  output hwl_pkg::hwl_cmd_t     cmd,
  output hwl_pkg::hwl_level_t   level
);

  // --------------------------------------------------
  // decode
  // --------------------------------------------------

  hwl_pkg::hwl_op_e op;

  // opcode and funct3 fields
  logic [6:0] opc;
  logic [2:0] f3;

  assign opc = inst[6:0];
  assign f3 = inst[14:12];

  // nothing decodes unless the instruction is valid
  always_comb begin
    op = hwl_pkg::op_none;
    if (ena_inst) begin
      if (opc == hwl_pkg::HWL_OPC_CFG) begin
        op = hwl_pkg::op_cfg;
      end else if (opc == hwl_pkg::HWL_OPC_MERGE && f3 == hwl_pkg::HWL_F3_MERGE) begin
        op = hwl_pkg::op_merge;
      end
    end
  end

  // command for the register file
  always_comb begin
    cmd.op = op;
    cmd.addr = wa;
    // cfg carries wd, merge carries the immediate
    cmd.data = (op == hwl_pkg::op_cfg) ? wd : imm;
  end

  // --------------------------------------------------
  // nesting level
  // --------------------------------------------------

  // top level reached, no further push
  logic at_top;
  // pop would go past level 0
  logic pop_under;

  assign at_top = (level == 3'd7);
  assign pop_under = (pop >= level);

  // merge pushes one level
  // fall through drops the whole exited run
  always_ff @(posedge clk) begin
    if (rst) begin
      level <= '0;
    end else if (op == hwl_pkg::op_merge) begin
      if (!at_top) begin
        level <= level + 3'd1;
      end
    end else if (fall_thru) begin
      // floor at zero
      if (pop_under) begin
        level <= '0;
      end else begin
        level <= level - pop;
      end
    end
  end

endmodule

// ==== rtl/hwl_exit_count.sv ====
`timescale 1ns/1ps

module hwl_exit_count (
  input  hwl_pkg::hwl_level_t                level,
  input  logic [hwl_pkg::HWL_DEPTH-1:0]      zero_vec,
  output hwl_pkg::hwl_level_t                pop
);

  // flags of the enclosing levels only, level-1 down to 1
  logic [hwl_pkg::HWL_DEPTH-1:0] below_mask;
  logic [hwl_pkg::HWL_DEPTH-1:0] masked;
  // level-1 shifted up to the msb
  logic [hwl_pkg::HWL_DEPTH-1:0] aligned;
  // length of the zero run below the active level
  hwl_pkg::hwl_level_t run_len;
  logic run;

  // bits 0..level-1 set, then bit 0 dropped since level 0 is idle
  assign below_mask = ((hwl_pkg::HWL_DEPTH'(1) << level) - 1'b1) &
                      ~hwl_pkg::HWL_DEPTH'(1);
  assign masked = zero_vec & below_mask;
  assign aligned = masked << (hwl_pkg::HWL_DEPTH - level);

  // leading ones from the msb down
  // stops at the first enclosing loop that still has trips left
  always_comb begin
    run = 1'b1;
    run_len = '0;
    for (int j = hwl_pkg::HWL_DEPTH - 1; j >= 0; j--) begin
      if (run && aligned[j]) begin
        run_len = run_len + 3'd1;
      end else begin
        run = 1'b0;
      end
    end
  end

  // the active level itself always exits
  assign pop = run_len + 3'd1;

endmodule

// ==== rtl/hwl_pc_redirect.sv ====
`timescale 1ns/1ps

module hwl_pc_redirect (
  input  logic [31:0]           pc,
  input  logic                  ena_inst,
  input  hwl_pkg::hwl_level_t   level,
  input  hwl_pkg::hwl_entry_t   cur,
  output logic                  redirect,
  output logic                  fall_thru,
  output logic [1:0]            pc_sel_upper,
  output logic [31:0]           pc_next
);

  // --------------------------------------------------
  // loop addresses
  // --------------------------------------------------

  // end index needs one extra bit for start + len
  logic [9:0] end_idx;
  logic [31:0] end_pc;
  logic [31:0] start_pc;

  assign end_idx = {1'b0, cur.start} + {4'b0, cur.len};

  // word index to byte address
  assign end_pc = hwl_pkg::HWL_BASE_PC + {20'b0, end_idx, 2'b00};
  assign start_pc = hwl_pkg::HWL_BASE_PC + {21'b0, cur.start, 2'b00};

  // --------------------------------------------------
  // end detect and select
  // --------------------------------------------------

  logic active;
  logic at_end;
  logic cnt_zero;

  assign active = (level != '0);
  assign at_end = active && ena_inst && (pc == end_pc);
  assign cnt_zero = (cur.count == 12'd0);

  // trips left, jump back
  assign redirect = at_end && !cnt_zero;
  // last trip done, fetch continues past the body
  assign fall_thru = at_end && cnt_zero;

  always_comb begin
    if (redirect) begin
      pc_sel_upper = hwl_pkg::HWL_PCSEL_LOOP;
      pc_next = start_pc;
    end else begin
      pc_sel_upper = hwl_pkg::HWL_PCSEL_SEQ;
      pc_next = pc;
    end
  end

endmodule

// ==== rtl/hwl_top.sv ====
`timescale 1ns/1ps

module hwl_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [31:0]           pc,
  input  logic [31:0]           inst,
  input  logic                  ena_inst,
  input  logic [2:0]            wa,
  input  logic [31:0]           wd,
  input  logic [31:0]           imm,
  output logic [1:0]            pc_sel_upper,
  output logic [31:0]           pc_next,
  output hwl_pkg::hwl_level_t   loop_level,
  output logic [11:0]           loop_count
);

  // --------------------------------------------------
  // internal links
  // --------------------------------------------------

  hwl_pkg::hwl_cmd_t cmd;
  hwl_pkg::hwl_level_t level;
  hwl_pkg::hwl_level_t pop;
  hwl_pkg::hwl_entry_t cur;
  logic [hwl_pkg::HWL_DEPTH-1:0] zero_vec;
  // redirect doubles as the decrement strobe
  logic redirect;
  logic fall_thru;

  // decode and level register
  hwl_level_tracker hwl_level_tracker_i (
    .clk       (clk),
    .rst       (rst),
    .inst      (inst),
    .ena_inst  (ena_inst),
    .wa        (wa),
    .wd        (wd),
    .imm       (imm),
    .fall_thru (fall_thru),
    .pop       (pop),
    .cmd       (cmd),
    .level     (level)
  );

  // loop entries
  hwl_loop_regfile hwl_loop_regfile_i (
    .clk      (clk),
    .rst      (rst),
    .cmd      (cmd),
    .level    (level),
    .dec      (redirect),
    .cur      (cur),
    .zero_vec (zero_vec)
  );

  // how many levels a fall through leaves
  hwl_exit_count hwl_exit_count_i (
    .level    (level),
    .zero_vec (zero_vec),
    .pop      (pop)
  );

  // end compare and next pc
  hwl_pc_redirect hwl_pc_redirect_i (
    .pc           (pc),
    .ena_inst     (ena_inst),
    .level        (level),
    .cur          (cur),
    .redirect     (redirect),
    .fall_thru    (fall_thru),
    .pc_sel_upper (pc_sel_upper),
    .pc_next      (pc_next)
  );

  assign loop_level = level;
  assign loop_count = cur.count;

endmodule

// ==== bench/hwl_clk_gen.sv ====
`timescale 1ns/1ps

module hwl_clk_gen (
  output logic clk,
  output logic rst
);

  // 4 ns period, first rising edge at 2 ns
  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  // reset high over the first two rising edges
  // released on a falling edge like every other input
  initial begin
    rst = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

// ==== bench/hwl_assert.sv ====
`timescale 1ns/1ps

module hwl_assert (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [31:0]           pc,
  input  logic                  ena_inst,
  input  logic [1:0]            pc_sel_upper,
  input  logic [31:0]           pc_next,
  input  hwl_pkg::hwl_level_t   loop_level,
  input  logic [11:0]           loop_count,
  input  hwl_pkg::hwl_entry_t   cur,
  input  logic                  redirect,
  input  hwl_pkg::hwl_cmd_t     cmd
);

  // assertion failures seen so far
  int fail_cnt = 0;

  // --------------------------------------------------
  // expected redirect from the active entry
  // --------------------------------------------------

  // loop end as byte address
  logic [31:0] loop_end;
  // active loop with a valid instruction at its end and trips left
  logic exp_redirect;

  assign loop_end = hwl_pkg::HWL_BASE_PC + ((32'(cur.start) + 32'(cur.len)) * 4);
  assign exp_redirect = (loop_level != '0) && ena_inst && (pc == loop_end) &&
                        (cur.count != 12'd0);

  // --------------------------------------------------
  // properties
  // --------------------------------------------------

  // level cleared by reset
  a_reset_level: assert property (@(posedge clk) rst |=> (loop_level == '0))
    else begin
      $error("loop_level not zero in the cycle after reset");
      fail_cnt++;
    end

  // select code set only on redirect
  a_sel_redirect: assert property (@(posedge clk) disable iff (rst)
    ((pc_sel_upper == 2'd2) == exp_redirect))
    else begin
      $error("pc_sel_upper does not follow redirect");
      fail_cnt++;
    end

  // sequential fetch passes pc through
  a_pc_pass: assert property (@(posedge clk) disable iff (rst)
    !exp_redirect |-> (pc_next == pc))
    else begin
      $error("pc_next differs from pc without a redirect");
      fail_cnt++;
    end

  // a plain redirect costs one trip
  a_dec: assert property (@(posedge clk) disable iff (rst)
    (redirect && cmd.op == hwl_pkg::op_none) |=> (loop_count == $past(loop_count) - 12'd1))
    else begin
      $error("loop_count did not drop by one after a redirect");
      fail_cnt++;
    end

  // push at the top level must hold at 7
  a_no_wrap: assert property (@(posedge clk) disable iff (rst)
    (loop_level == 3'd7 && cmd.op == hwl_pkg::op_merge) |=> (loop_level == 3'd7))
    else begin
      $error("loop_level wrapped past 7");
      fail_cnt++;
    end

endmodule

bind hwl_top hwl_assert hwl_assert_i (
  .clk          (clk),
  .rst          (rst),
  .pc           (pc),
  .ena_inst     (ena_inst),
  .pc_sel_upper (pc_sel_upper),
  .pc_next      (pc_next),
  .loop_level   (loop_level),
  .loop_count   (loop_count),
  .cur          (cur),
  .redirect     (redirect),
  .cmd          (cmd)
);

// ==== bench/hwl_tb.sv ====
`timescale 1ns/1ps

module hwl_tb;

  // --------------------------------------------------
  // DUT and clock
  // --------------------------------------------------

  logic clk;
  logic rst;
  logic [31:0] pc;
  logic [31:0] inst;
  logic ena_inst;
  logic [2:0] wa;
  logic [31:0] wd;
  logic [31:0] imm;
  logic [1:0] pc_sel_upper;
  logic [31:0] pc_next;
  hwl_pkg::hwl_level_t loop_level;
  logic [11:0] loop_count;

  // custom instruction words with opcode in 6:0 and funct3 in 14:12
  localparam logic [31:0] cfg_inst = 32'h0000_003c;
  localparam logic [31:0] merge_inst = 32'h0000_2014;

  hwl_clk_gen hwl_clk_gen_i (
    .clk (clk),
    .rst (rst)
  );

  hwl_top hwl_top_i (
    .clk          (clk),
    .rst          (rst),
    .pc           (pc),
    .inst         (inst),
    .ena_inst     (ena_inst),
    .wa           (wa),
    .wd           (wd),
    .imm          (imm),
    .pc_sel_upper (pc_sel_upper),
    .pc_next      (pc_next),
    .loop_level   (loop_level),
    .loop_count   (loop_count)
  );

  // reference copy of entries and level
  hwl_pkg::hwl_entry_t model_ent [8];
  hwl_pkg::hwl_level_t model_level;
  logic [31:0] lfsr_state = 32'h7e3;
  int errs = 0;
  int n_pass = 0;
  int n_fail = 0;
  int test_mark = 0;

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------

  // galois form with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic lsb;
    lsb = s[0];
    s = s >> 1;
    if (lsb) s = s ^ 32'h8020_0003;
    return s;
  endfunction

  // one lfsr step per bit
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  function automatic hwl_pkg::hwl_entry_t make_entry(input int s, input int l, input int c);
    hwl_pkg::hwl_entry_t e;
    e.start = s[8:0];
    e.len = l[5:0];
    e.tag = '0;
    e.count = c[11:0];
    return e;
  endfunction

  // byte addresses from word indices
  function automatic logic [31:0] start_addr(input hwl_pkg::hwl_entry_t e);
    return 32'h1000_0000 + 32'(e.start) * 4;
  endfunction

  function automatic logic [31:0] end_addr(input hwl_pkg::hwl_entry_t e);
    return 32'h1000_0000 + (32'(e.start) + 32'(e.len)) * 4;
  endfunction

  // active level plus enclosing levels already at zero
  function automatic int exit_levels(input int lvl);
    int n;
    n = 1;
    for (int j = lvl - 1; j >= 1; j--) begin
      if (model_ent[j].count != 12'd0) break;
      n++;
    end
    return n;
  endfunction

  function automatic int total_errors();
    return errs + hwl_top_i.hwl_assert_i.fail_cnt;
  endfunction

  task automatic check_val(input string name, input string sig,
                           input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("FAILED %s %s: expected %0h actual %0h", name, sig, exp, act);
      errs++;
    end
  endtask

  // drive one cycle, check against the model, then advance the model
  task automatic run_cycle(input string name, input logic [31:0] inst_v, input logic ena_v,
                           input logic [2:0] wa_v, input logic [31:0] data_v,
                           input logic [31:0] pc_v);
    logic is_cfg;
    logic is_merge;
    logic at_end;
    logic redir;
    int pop;
    hwl_pkg::hwl_entry_t cur_e;
    @(negedge clk);
    inst = inst_v;
    ena_inst = ena_v;
    wa = wa_v;
    wd = data_v;
    imm = data_v;
    pc = pc_v;
    #1;
    is_cfg = ena_v && inst_v[6:0] == 7'h3c;
    is_merge = ena_v && !is_cfg && inst_v[6:0] == 7'h14 && inst_v[14:12] == 3'h2;
    cur_e = model_ent[model_level];
    at_end = model_level != 0 && ena_v && pc_v == end_addr(cur_e);
    redir = at_end && cur_e.count != 12'd0;
    check_val(name, "loop_level", 32'(model_level), 32'(loop_level));
    check_val(name, "loop_count", 32'(cur_e.count), 32'(loop_count));
    check_val(name, "pc_sel_upper", redir ? 32'd2 : 32'd0, 32'(pc_sel_upper));
    check_val(name, "pc_next", redir ? start_addr(cur_e) : pc_v, pc_next);
    // writes win over the decrement
    if (is_cfg) begin
      model_ent[wa_v] = data_v;
    end else if (is_merge) begin
      model_ent[wa_v] = model_ent[wa_v] | data_v;
    end else if (redir) begin
      model_ent[model_level].count = cur_e.count - 12'd1;
    end
    if (is_merge) begin
      if (model_level != 3'd7) model_level = model_level + 3'd1;
    end else if (at_end && !redir) begin
      pop = exit_levels(model_level);
      model_level = (pop >= model_level) ? 3'd0 : model_level - 3'(pop);
    end
  endtask

  task automatic idle_cycle(input string name);
    run_cycle(name, 32'h0, 1'b0, 3'd0, 32'h0, 32'h0);
  endtask

  task automatic wait_level(input string name, input logic [2:0] exp);
    int n;
    n = 0;
    while (loop_level !== exp && n < 8) begin
      idle_cycle(name);
      n++;
    end
    if (loop_level !== exp) begin
      $display("%s: timed out waiting for loop_level %0d", name, exp);
      errs++;
    end
  endtask

  task automatic start_test();
    test_mark = total_errors();
  endtask

  task automatic finish_test(input string name);
    int n;
    n = total_errors() - test_mark;
    if (n == 0) begin
      $display("%s: passed", name);
      n_pass++;
    end else begin
      $display("%s: failed with %0d errors", name, n);
      n_fail++;
    end
  endtask

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------

  initial begin
    logic [31:0] r;
    logic [31:0] ena_r;
    hwl_pkg::hwl_entry_t e;
    int n;
    pc = '0;
    inst = '0;
    ena_inst = 1'b0;
    wa = '0;
    wd = '0;
    imm = '0;
    model_level = '0;
    for (int i = 0; i < 8; i++) begin
      model_ent[i] = '0;
    end
    n = 0;
    while (rst !== 1'b0 && n < 16) begin
      @(negedge clk);
      n++;
    end
    if (rst !== 1'b0) begin
      $display("reset was never released");
      errs++;
    end

    // any pc passes through while idle after reset
    start_test();
    for (int i = 0; i < 6; i++) begin
      take_bits(32, r);
      take_bits(1, ena_r);
      run_cycle("reset_idle", 32'h0, ena_r[0], 3'd0, 32'h0, r);
    end
    finish_test("reset_idle");

    // configure then merge entry 1
    start_test();
    e = make_entry(16, 4, 12'h0a0);
    run_cycle("cfg_merge", cfg_inst, 1'b1, 3'd1, e, 32'h0);
    run_cycle("cfg_merge", merge_inst, 1'b1, 3'd1, 32'h0000_0005, 32'h0);
    idle_cycle("cfg_merge");
    check_val("cfg_merge", "merged count", 32'h0a5, 32'(loop_count));
    finish_test("cfg_merge");

    // random body with count 1 to 6 and one redirect per trip
    start_test();
    take_bits(9, r);
    e.start = r[8:0];
    take_bits(6, r);
    e.len = r[5:0];
    take_bits(3, r);
    e.tag = '0;
    e.count = 12'(r % 6 + 1);
    n = e.count;
    run_cycle("redirect_count", cfg_inst, 1'b1, 3'd1, e, 32'h0);
    for (int i = 0; i < n; i++) begin
      run_cycle("redirect_count", 32'h0, 1'b1, 3'd0, 32'h0, end_addr(e));
    end
    idle_cycle("redirect_count");
    finish_test("redirect_count");

    // count now zero so the end address falls through
    start_test();
    run_cycle("fall_thru", 32'h0, 1'b1, 3'd0, 32'h0, end_addr(e));
    wait_level("fall_thru", 3'd0);
    finish_test("fall_thru");

    // outer already done so the inner exit pops both
    start_test();
    run_cycle("nest_exit", cfg_inst, 1'b1, 3'd1, make_entry(32, 24, 0), 32'h0);
    e = make_entry(36, 4, 1);
    run_cycle("nest_exit", cfg_inst, 1'b1, 3'd2, e, 32'h0);
    run_cycle("nest_exit", merge_inst, 1'b1, 3'd1, 32'h0, 32'h0);
    run_cycle("nest_exit", merge_inst, 1'b1, 3'd2, 32'h0, 32'h0);
    idle_cycle("nest_exit");
    check_val("nest_exit", "level before exit", 32'd2, 32'(loop_level));
    run_cycle("nest_exit", 32'h0, 1'b1, 3'd0, 32'h0, end_addr(e));
    run_cycle("nest_exit", 32'h0, 1'b1, 3'd0, 32'h0, end_addr(e));
    wait_level("nest_exit", 3'd0);
    finish_test("nest_exit");

    // end address without ena_inst and then at level 0
    start_test();
    e = make_entry(100, 6, 3);
    run_cycle("no_redirect", cfg_inst, 1'b1, 3'd1, e, 32'h0);
    run_cycle("no_redirect", merge_inst, 1'b1, 3'd1, 32'h0, 32'h0);
    run_cycle("no_redirect", 32'h0, 1'b0, 3'd0, 32'h0, end_addr(e));
    idle_cycle("no_redirect");
    e.count = '0;
    run_cycle("no_redirect", cfg_inst, 1'b1, 3'd1, e, 32'h0);
    run_cycle("no_redirect", 32'h0, 1'b1, 3'd0, 32'h0, end_addr(e));
    wait_level("no_redirect", 3'd0);
    e = make_entry(8, 2, 5);
    run_cycle("no_redirect", cfg_inst, 1'b1, 3'd0, e, 32'h0);
    run_cycle("no_redirect", 32'h0, 1'b1, 3'd0, 32'h0, end_addr(e));
    idle_cycle("no_redirect");
    check_val("no_redirect", "level 0 count", 32'd5, 32'(loop_count));
    idle_cycle("no_redirect");
    finish_test("no_redirect");

    // pushes beyond the deepest level hold at 7
    start_test();
    for (int i = 0; i < 9; i++) begin
      run_cycle("level_saturate", merge_inst, 1'b1, 3'd3, 32'h0, 32'h0);
    end
    idle_cycle("level_saturate");
    idle_cycle("level_saturate");
    finish_test("level_saturate");

    $display("tests passed %0d, failed %0d, errors %0d", n_pass, n_fail, total_errors());
    if (n_fail == 0 && total_errors() == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // backstop in case the stimulus stalls
  initial begin
    #50000;
    $display("simulation stalled and the watchdog expired");
    $display("Test FAILED");
    $finish;
  end

endmodule

// ==== hwl.f ====
rtl/hwl_pkg.sv
rtl/hwl_loop_regfile.sv
rtl/hwl_level_tracker.sv
rtl/hwl_exit_count.sv
rtl/hwl_pc_redirect.sv
rtl/hwl_top.sv
bench/hwl_clk_gen.sv
bench/hwl_assert.sv
bench/hwl_tb.sv
